// ==== dv/tb_peripheral_subsystem.sv ====
// Testbench for the peripheral subsystem
// External peripheral model, transaction table and compare tasks
`timescale 1ns/10ps

module tb_peripheral_subsystem;

  import periph_pkg::*;

  localparam logic [1:0] OP_WR   = 2'd0;
  localparam logic [1:0] OP_RD   = 2'd1;
  localparam logic [1:0] OP_INTR = 2'd2;
  localparam logic [1:0] OP_LVL  = 2'd3;

  // Level rows use the address field to pick the output
  localparam logic [31:0] LVL_EXIT_VALID = 32'd0;
  localparam logic [31:0] LVL_EXIT_VALUE = 32'd1;
  localparam logic [31:0] LVL_IRQ        = 32'd2;
  localparam logic [31:0] LVL_MSIP       = 32'd3;

  typedef struct packed {
    logic [1:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
    logic [31:0] exp_rdata;
    logic        exp_err;
  } row_t;

  logic        clk = 1'b0;
  logic        reset = 1'b1;
  obi_req_t    obi_req = '0;
  obi_rsp_t    obi_rsp;
  logic [7:0]  intr = '0;
  reg_req_t    ext_req;
  reg_rsp_t    ext_rsp = '0;
  logic        exit_valid;
  logic [31:0] exit_value;
  logic        irq;
  logic        msip;
  logic [31:0] mem [16];
  logic        busy = 1'b0;
  int unsigned stall = 0;
  row_t        rows[$];

  peripheral_subsystem DUT (
    .clk_i        (clk),
    .reset_i      (reset),
    .obi_req_i    (obi_req),
    .obi_rsp_o    (obi_rsp),
    .exit_valid_o (exit_valid),
    .exit_value_o (exit_value),
    .intr_i       (intr),
    .irq_o        (irq),
    .msip_o       (msip),
    .ext_req_o    (ext_req),
    .ext_rsp_i    (ext_rsp)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // External peripheral, ready raised after a random stall
  initial begin
    void'($urandom(32'h93126e5e));
    forever begin
      @(posedge clk);
      if (reset) begin
        ext_rsp <= '0;
        busy    <= 1'b0;
      end else if (ext_rsp.ready) begin
        if (ext_req.write) begin
          for (int b = 0; b < 4; b++) begin
            if (ext_req.wstrb[b]) begin
              mem[ext_req.addr[5:2]][8*b +: 8] <= ext_req.wdata[8*b +: 8];
            end
          end
        end
        ext_rsp.ready <= 1'b0;
        busy          <= 1'b0;
      end else if (ext_req.valid) begin
        if (!busy) begin
          busy  <= 1'b1;
          stall <= $urandom % 4;
        end else if (stall == 0) begin
          ext_rsp.ready <= 1'b1;
          ext_rsp.rdata <= mem[ext_req.addr[5:2]];
        end else begin
          stall <= stall - 1;
        end
      end
    end
  end

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_rsp(input obi_rsp_t exp, input obi_rsp_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED obi_rsp_o exp=%h act=%h", exp, act));
    end
  endtask

  task automatic check_ext(input reg_req_t exp, input reg_req_t act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED ext_req_o exp=%h act=%h", exp, act));
    end
  endtask

  task automatic check_level(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s exp=%h act=%h", name, exp, act));
    end
  endtask

  task automatic await_grant();
    int n;
    n = 0;
    @(negedge clk);
    while (!obi_rsp.gnt && n < 50) begin
      n++;
      @(negedge clk);
    end
    if (!obi_rsp.gnt) begin
      abort_run("Timed out waiting for gnt on the OBI port");
    end
  endtask

  task automatic await_response();
    int n;
    n = 0;
    @(negedge clk);
    while (!obi_rsp.rvalid && n < 50) begin
      n++;
      @(negedge clk);
    end
    if (!obi_rsp.rvalid) begin
      abort_run("Timed out waiting for rvalid on the OBI port");
    end
  endtask

  task automatic run_access(input row_t row);
    obi_rsp_t exp_rsp;
    reg_req_t exp_ext;
    logic     is_ext;
    exp_rsp = '{gnt: 1'b0, rvalid: 1'b1, err: row.exp_err, rdata: row.exp_rdata};
    exp_ext = '{valid: 1'b1, write: (row.op == OP_WR), wstrb: row.be,
                addr: row.addr, wdata: row.wdata};
    is_ext  = (row.addr[31:12] == 20'h00002);
    @(posedge clk);
    obi_req <= '{req: 1'b1, we: (row.op == OP_WR), be: row.be,
                 addr: row.addr, wdata: row.wdata};
    await_grant();
    if (is_ext) begin
      check_level("ext_rsp_i.ready at gnt", 32'd1, {31'b0, ext_rsp.ready});
      check_ext(exp_ext, ext_req);
    end
    @(posedge clk);
    obi_req <= '0;
    await_response();
    check_rsp(exp_rsp, obi_rsp);
  endtask

  task automatic check_output(input row_t row);
    repeat (2) @(negedge clk);
    case (row.addr)
      LVL_EXIT_VALID: check_level("exit_valid_o", row.exp_rdata, {31'b0, exit_valid});
      LVL_EXIT_VALUE: check_level("exit_value_o", row.exp_rdata, exit_value);
      LVL_IRQ:        check_level("irq_o", row.exp_rdata, {31'b0, irq});
      default:        check_level("msip_o", row.exp_rdata, {31'b0, msip});
    endcase
  endtask

  function automatic void add_row(input logic [1:0] op, input logic [31:0] addr,
                                  input logic [31:0] wdata, input logic [3:0] be,
                                  input logic [31:0] exp_rdata, input logic exp_err);
    rows.push_back('{op, addr, wdata, be, exp_rdata, exp_err});
  endfunction

  initial begin
    for (int i = 0; i < 16; i++) begin
      mem[i] = {16'hF00D, 16'h2000 + 16'(4 * i)};
    end
    // System control, scratch merge and exit
    add_row(OP_WR, 32'h0000_0008, 32'h1122_3344, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_WR, 32'h0000_0008, 32'hAABB_CCDD, 4'h5, 32'h0000_0000, 1'b0);
    add_row(OP_RD, 32'h0000_0008, 32'h0000_0000, 4'hF, 32'h11BB_33DD, 1'b0);
    add_row(OP_WR, 32'h0000_0004, 32'h0000_002A, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_WR, 32'h0000_0000, 32'h0000_0001, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_LVL, LVL_EXIT_VALID, 32'h0, 4'h0, 32'h0000_0001, 1'b0);
    add_row(OP_LVL, LVL_EXIT_VALUE, 32'h0, 4'h0, 32'h0000_002A, 1'b0);
    // Unmapped accesses, scratch must be untouched
    add_row(OP_RD, 32'h0000_3000, 32'h0000_0000, 4'hF, 32'hBADC_AB1E, 1'b1);
    add_row(OP_WR, 32'h0000_3000, 32'h0000_0055, 4'hF, 32'hBADC_AB1E, 1'b1);
    add_row(OP_RD, 32'h0001_0000, 32'h0000_0000, 4'hF, 32'hBADC_AB1E, 1'b1);
    add_row(OP_WR, 32'h0001_0008, 32'h0000_0000, 4'hF, 32'hBADC_AB1E, 1'b1);
    add_row(OP_RD, 32'h0000_0008, 32'h0000_0000, 4'hF, 32'h11BB_33DD, 1'b0);
    // External port under random stalls
    add_row(OP_WR, 32'h0000_2000, 32'hCAFE_0001, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_WR, 32'h0000_2008, 32'hA5A5_A5A5, 4'h3, 32'h0000_0000, 1'b0);
    add_row(OP_WR, 32'h0000_203C, 32'hDEAD_BEEF, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_RD, 32'h0000_2000, 32'h0000_0000, 4'hF, 32'hCAFE_0001, 1'b0);
    add_row(OP_RD, 32'h0000_2008, 32'h0000_0000, 4'hF, 32'hF00D_A5A5, 1'b0);
    add_row(OP_RD, 32'h0000_2010, 32'h0000_0000, 4'hF, 32'hF00D_2010, 1'b0);
    add_row(OP_RD, 32'h0000_203C, 32'h0000_0000, 4'hF, 32'hDEAD_BEEF, 1'b0);
    // Pulse sources 2 and 5, then enable and claim
    add_row(OP_INTR, 32'h0, 32'h0000_0024, 4'h0, 32'h0, 1'b0);
    add_row(OP_INTR, 32'h0, 32'h0000_0000, 4'h0, 32'h0, 1'b0);
    add_row(OP_RD, 32'h0000_1000, 32'h0000_0000, 4'hF, 32'h0000_0024, 1'b0);
    add_row(OP_LVL, LVL_IRQ, 32'h0, 4'h0, 32'h0000_0000, 1'b0);
    add_row(OP_WR, 32'h0000_1004, 32'h0000_0020, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_LVL, LVL_IRQ, 32'h0, 4'h0, 32'h0000_0001, 1'b0);
    add_row(OP_WR, 32'h0000_1004, 32'h0000_0024, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_RD, 32'h0000_1008, 32'h0000_0000, 4'hF, 32'h0000_0003, 1'b0);
    add_row(OP_RD, 32'h0000_1008, 32'h0000_0000, 4'hF, 32'h0000_0006, 1'b0);
    add_row(OP_RD, 32'h0000_1008, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_RD, 32'h0000_1000, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_LVL, LVL_IRQ, 32'h0, 4'h0, 32'h0000_0000, 1'b0);
    // Software interrupt
    add_row(OP_WR, 32'h0000_100C, 32'h0000_0001, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_LVL, LVL_MSIP, 32'h0, 4'h0, 32'h0000_0001, 1'b0);
    add_row(OP_RD, 32'h0000_100C, 32'h0000_0000, 4'hF, 32'h0000_0001, 1'b0);
    add_row(OP_WR, 32'h0000_100C, 32'h0000_0000, 4'hF, 32'h0000_0000, 1'b0);
    add_row(OP_LVL, LVL_MSIP, 32'h0, 4'h0, 32'h0000_0000, 1'b0);

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    foreach (rows[i]) begin
      case (rows[i].op)
        OP_INTR: begin
          @(posedge clk);
          intr <= rows[i].wdata[7:0];
          repeat (2) @(posedge clk);
        end
        OP_LVL:  check_output(rows[i]);
        default: run_access(rows[i]);
      endcase
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== src/irq_ctrl.sv ====
// Interrupt controller with edge-captured pending bits and enable mask
// Lowest-index claim register and software interrupt bit
`timescale 1ns/10ps

module irq_ctrl #(
  parameter int NUM_SRC = 8
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  input  logic [NUM_SRC-1:0]   intr_i,
  output logic                 irq_o,
  output logic                 msip_o
);

  import periph_pkg::*;

  logic [NUM_SRC-1:0] intr_sync_q;
  logic [NUM_SRC-1:0] intr_prev_q;
  logic [NUM_SRC-1:0] src_edge;
  logic [NUM_SRC-1:0] pending_q;
  logic [NUM_SRC-1:0] enable_q;
  logic [NUM_SRC-1:0] active;
  logic [NUM_SRC-1:0] claim_oh;
  logic [NUM_SRC-1:0] clr;
  logic [31:0]        claim_id;
  logic               msip_q;
  logic               irq_q;
  logic [11:0]        ofs;
  logic               wr_en;
  logic               claim_rd;
  logic [31:0]        rdata;

  assign ofs      = reg_req_i.addr[11:0];
  assign wr_en    = reg_req_i.valid & reg_req_i.write;
  assign claim_rd = reg_req_i.valid & ~reg_req_i.write & (ofs == CLAIM_OFS);

  // One sync stage, then one stage for the edge compare
  assign src_edge = intr_sync_q & ~intr_prev_q;
  assign active   = pending_q & enable_q;

  always_comb begin
    claim_id = '0;
    claim_oh = '0;
    // Walk downwards so the lowest active source is kept
    for (int i = NUM_SRC - 1; i >= 0; i--) begin
      if (active[i]) begin
        claim_id    = 32'(i + 1);
        claim_oh    = '0;
        claim_oh[i] = 1'b1;
      end
    end
  end

  assign clr = claim_rd ? claim_oh : '0;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      intr_sync_q <= '0;
      intr_prev_q <= '0;
      pending_q   <= '0;
      enable_q    <= '0;
      msip_q      <= 1'b0;
      irq_q       <= 1'b0;
    end else begin
      intr_sync_q <= intr_i;
      intr_prev_q <= intr_sync_q;
      // New edge beats a claim in the same cycle
      pending_q   <= (pending_q & ~clr) | src_edge;
      irq_q       <= |active;
      if (wr_en && ofs == ENABLE_OFS) begin
        enable_q <= NUM_SRC'(strb_merge(32'(enable_q), reg_req_i.wdata, reg_req_i.wstrb));
      end
      if (wr_en && ofs == MSIP_OFS && reg_req_i.wstrb[0]) begin
        msip_q <= reg_req_i.wdata[0];
      end
    end
  end

  always_comb begin
    case (ofs)
      PENDING_OFS: rdata = 32'(pending_q);
      ENABLE_OFS:  rdata = 32'(enable_q);
      CLAIM_OFS:   rdata = claim_id;
      MSIP_OFS:    rdata = {31'b0, msip_q};
      default:     rdata = '0;
    endcase
  end

  assign reg_rsp_o.ready = 1'b1;
  assign reg_rsp_o.error = 1'b0;
  assign reg_rsp_o.rdata = rdata;

  assign irq_o  = irq_q;
  assign msip_o = msip_q;

  // Pending bits only drop through a claim of a bit that was set
  a_claim_clears_pending: assert property (@(posedge clk_i) disable iff (reset_i)
    1'b1 |=> (($past(pending_q) & ~pending_q) == ($past(clr) & ~$past(src_edge))));

endmodule

// ==== src/obi_to_reg.sv ====
// OBI slave port to register bus bridge
// Combinational request path, one-cycle response register
`timescale 1ns/10ps

module obi_to_reg (
  input  logic                clk_i,
  input  logic                reset_i,
  input  periph_pkg::obi_req_t obi_req_i,
  output periph_pkg::obi_rsp_t obi_rsp_o,
  output periph_pkg::reg_req_t reg_req_o,
  input  periph_pkg::reg_rsp_t reg_rsp_i
);

  import periph_pkg::*;

  logic        gnt;
  logic        rvalid_q;
  logic        err_q;
  logic [31:0] rdata_q;

  assign reg_req_o.valid = obi_req_i.req;
  assign reg_req_o.write = obi_req_i.we;
  assign reg_req_o.wstrb = obi_req_i.be;
  assign reg_req_o.addr  = obi_req_i.addr;
  assign reg_req_o.wdata = obi_req_i.wdata;

  // Grant as soon as the target completes the transfer
  assign gnt = obi_req_i.req & reg_rsp_i.ready;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
      rdata_q  <= '0;
    end else begin
      rvalid_q <= gnt;
      if (gnt) begin
        err_q <= reg_rsp_i.error;
        // Writes return zero unless the access failed
        rdata_q <= (obi_req_i.we && !reg_rsp_i.error) ? '0 : reg_rsp_i.rdata;
      end
    end
  end

  assign obi_rsp_o.gnt    = gnt;
  assign obi_rsp_o.rvalid = rvalid_q;
  assign obi_rsp_o.err    = err_q;
  assign obi_rsp_o.rdata  = rdata_q;

  // Master keeps the request and its payload until the grant
  a_req_held_until_gnt: assert property (@(posedge clk_i) disable iff (reset_i)
    obi_req_i.req && !gnt |=> obi_req_i.req && $stable(obi_req_i));

endmodule

// ==== src/periph_pkg.sv ====
// OBI and register bus request/response structs
// Address map, target indices and register offsets
// Byte-strobe merge helper shared by the register targets
package periph_pkg;

  typedef struct packed {
    logic        req;
    logic        we;
    logic [3:0]  be;
    logic [31:0] addr;
    logic [31:0] wdata;
  } obi_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic        err;
    logic [31:0] rdata;
  } obi_rsp_t;

  typedef struct packed {
    logic        valid;
    logic        write;
    logic [3:0]  wstrb;
    logic [31:0] addr;
    logic [31:0] wdata;
  } reg_req_t;

  typedef struct packed {
    logic        ready;
    logic        error;
    logic [31:0] rdata;
  } reg_rsp_t;

  localparam int TARGET_SOC_CTRL = 0;
  localparam int TARGET_IRQ      = 1;
  localparam int TARGET_EXT      = 2;
  localparam int NUM_TARGETS     = 3;

  // 4 KB regions inside the low 64 KB
  localparam logic [31:0] SOC_CTRL_BASE = 32'h0000_0000;
  localparam logic [31:0] IRQ_BASE      = 32'h0000_1000;
  localparam logic [31:0] EXT_BASE      = 32'h0000_2000;

  localparam logic [11:0] EXIT_VALID_OFS = 12'h000;
  localparam logic [11:0] EXIT_VALUE_OFS = 12'h004;
  localparam logic [11:0] SCRATCH_OFS    = 12'h008;

  localparam logic [11:0] PENDING_OFS = 12'h000;
  localparam logic [11:0] ENABLE_OFS  = 12'h004;
  localparam logic [11:0] CLAIM_OFS   = 12'h008;
  localparam logic [11:0] MSIP_OFS    = 12'h00C;

  localparam logic [31:0] DECODE_ERR_DATA = 32'hBADC_AB1E;

  function automatic logic [31:0] strb_merge(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage

// ==== src/peripheral_subsystem.sv ====
// Peripheral subsystem top level
// OBI bridge, register demux, system control, interrupt controller, external port
`timescale 1ns/10ps

module peripheral_subsystem #(
  parameter int NUM_SRC = 8
) (
  input  logic                 clk_i,
  input  logic                 reset_i,

  input  periph_pkg::obi_req_t obi_req_i,
  output periph_pkg::obi_rsp_t obi_rsp_o,

  output logic                 exit_valid_o,
  output logic [31:0]          exit_value_o,

  input  logic [NUM_SRC-1:0]   intr_i,
  output logic                 irq_o,
  output logic                 msip_o,

  output periph_pkg::reg_req_t ext_req_o,
  input  periph_pkg::reg_rsp_t ext_rsp_i
);

  import periph_pkg::*;

  reg_req_t                   reg_req;
  reg_rsp_t                   reg_rsp;
  reg_req_t [NUM_TARGETS-1:0] tgt_req;
  reg_rsp_t [NUM_TARGETS-1:0] tgt_rsp;

  obi_to_reg obi_to_reg_i (
    .clk_i,
    .reset_i,
    .obi_req_i,
    .obi_rsp_o,
    .reg_req_o (reg_req),
    .reg_rsp_i (reg_rsp)
  );

  reg_demux reg_demux_i (
    .clk_i,
    .reg_req_i (reg_req),
    .reg_rsp_o (reg_rsp),
    .tgt_req_o (tgt_req),
    .tgt_rsp_i (tgt_rsp)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .reset_i,
    .reg_req_i (tgt_req[TARGET_SOC_CTRL]),
    .reg_rsp_o (tgt_rsp[TARGET_SOC_CTRL]),
    .exit_valid_o,
    .exit_value_o
  );

  irq_ctrl #(
    .NUM_SRC (NUM_SRC)
  ) irq_ctrl_i (
    .clk_i,
    .reset_i,
    .reg_req_i (tgt_req[TARGET_IRQ]),
    .reg_rsp_o (tgt_rsp[TARGET_IRQ]),
    .intr_i,
    .irq_o,
    .msip_o
  );

  // External peripheral slot
  assign ext_req_o            = tgt_req[TARGET_EXT];
  assign tgt_rsp[TARGET_EXT]  = ext_rsp_i;

endmodule

// ==== src/reg_demux.sv ====
// Register bus address decoder and demultiplexer
// Routes requests to one target and returns its response or a decode error
`timescale 1ns/10ps

module reg_demux (
  input  logic                                             clk_i,
  input  periph_pkg::reg_req_t                             reg_req_i,
  output periph_pkg::reg_rsp_t                             reg_rsp_o,
  output periph_pkg::reg_req_t [periph_pkg::NUM_TARGETS-1:0] tgt_req_o,
  input  periph_pkg::reg_rsp_t [periph_pkg::NUM_TARGETS-1:0] tgt_rsp_i
);

  import periph_pkg::*;

  logic [19:0]            region;
  logic [NUM_TARGETS-1:0] hit;
  logic [NUM_TARGETS-1:0] tgt_valid;

  // Upper address bits must be zero for any region to match
  assign region = reg_req_i.addr[31:12];

  assign hit[TARGET_SOC_CTRL] = (region == SOC_CTRL_BASE[31:12]);
  assign hit[TARGET_IRQ]      = (region == IRQ_BASE[31:12]);
  assign hit[TARGET_EXT]      = (region == EXT_BASE[31:12]);

  assign tgt_valid = hit & {NUM_TARGETS{reg_req_i.valid}};

  always_comb begin
    for (int i = 0; i < NUM_TARGETS; i++) begin
      tgt_req_o[i]       = reg_req_i;
      tgt_req_o[i].valid = tgt_valid[i];
    end
  end

  // Unmapped accesses complete at once with an error
  always_comb begin
    reg_rsp_o.ready = 1'b1;
    reg_rsp_o.error = 1'b1;
    reg_rsp_o.rdata = DECODE_ERR_DATA;
    for (int i = 0; i < NUM_TARGETS; i++) begin
      if (hit[i]) begin
        reg_rsp_o = tgt_rsp_i[i];
      end
    end
  end

  a_one_target_valid: assert property (@(posedge clk_i)
    $onehot0({tgt_req_o[TARGET_EXT].valid, tgt_req_o[TARGET_IRQ].valid,
              tgt_req_o[TARGET_SOC_CTRL].valid}));

endmodule

// ==== src/soc_ctrl.sv ====
// System-control registers: exit valid, exit value, scratch
`timescale 1ns/10ps

module soc_ctrl (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  periph_pkg::reg_req_t reg_req_i,
  output periph_pkg::reg_rsp_t reg_rsp_o,
  output logic                 exit_valid_o,
  output logic [31:0]          exit_value_o
);

  import periph_pkg::*;

  logic        exit_valid_q;
  logic [31:0] exit_value_q;
  logic [31:0] scratch_q;
  logic [11:0] ofs;
  logic        wr_en;
  logic [31:0] rdata;

  assign ofs   = reg_req_i.addr[11:0];
  assign wr_en = reg_req_i.valid & reg_req_i.write;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
      scratch_q    <= '0;
    end else if (wr_en) begin
      case (ofs)
        EXIT_VALID_OFS: begin
          if (reg_req_i.wstrb[0]) begin
            exit_valid_q <= reg_req_i.wdata[0];
          end
        end
        EXIT_VALUE_OFS: exit_value_q <= strb_merge(exit_value_q, reg_req_i.wdata, reg_req_i.wstrb);
        SCRATCH_OFS:    scratch_q    <= strb_merge(scratch_q, reg_req_i.wdata, reg_req_i.wstrb);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (ofs)
      EXIT_VALID_OFS: rdata = {31'b0, exit_valid_q};
      EXIT_VALUE_OFS: rdata = exit_value_q;
      SCRATCH_OFS:    rdata = scratch_q;
      default:        rdata = '0;
    endcase
  end

  assign reg_rsp_o.ready = 1'b1;
  assign reg_rsp_o.error = 1'b0;
  assign reg_rsp_o.rdata = rdata;

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// ==== vlog.f ====
src/periph_pkg.sv
src/obi_to_reg.sv
src/reg_demux.sv
src/soc_ctrl.sv
src/irq_ctrl.sv
src/peripheral_subsystem.sv
dv/tb_peripheral_subsystem.sv
